// ==== Makefile ====
# Verilator build and run of the data cache testbench

VERILATOR ?= verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := dcache_tb
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Test failures found
PASS_MSG  := All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/dcache_ctrl.sv ====
// Write-through, direct-mapped controller; fills win over processor requests
// Processor must hold and retry when a fill is present or memory grants tag 0
// No ordering between an outstanding fill and a later store to the same line

`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_ctrl (
  input  logic                         clock,
  input  logic                         rst_n,
  input  dcache_pkg::proc_req_t        proc_req,
  output dcache_pkg::proc_resp_t       proc_resp,
  output dcache_pkg::mem_req_t         mem_req,
  input  dcache_pkg::mem_resp_t        mem_resp,
  output dcache_pkg::cache_lookup_t    lookup,
  input  logic [`DCACHE_WORD_BITS-1:0] lookup_data,
  input  logic                         lookup_hit,
  output dcache_pkg::cache_write_t     cache_wr
);

  // Missed load addresses, indexed by the memory tag that was granted
  logic [`DCACHE_ADDR_BITS-1:0] miss_tbl [1:`MEM_TAG_COUNT];

  logic                         fill_cycle;
  logic                         is_load;
  logic                         is_store;
  logic                         miss_wr;
  logic [`DCACHE_ADDR_BITS-1:0] word_addr;
  dcache_pkg::dcache_addr_u     fill_addr;

  assign fill_cycle = (mem_resp.tag != '0);
  assign is_load    = (proc_req.cmd == dcache_pkg::BUS_LOAD);
  assign is_store   = (proc_req.cmd == dcache_pkg::BUS_STORE);

  // Memory only sees whole words
  assign word_addr = {proc_req.addr.raw[`DCACHE_ADDR_BITS-1:`DCACHE_OFS_BITS],
                      {`DCACHE_OFS_BITS{1'b0}}};

  // Storage is probed with the request address every cycle
  assign lookup.idx = proc_req.addr.f.idx;
  assign lookup.tag = proc_req.addr.f.tag;

  //////////////////////////////////////////////////
  // Request decision
  //////////////////////////////////////////////////

  always_comb begin
    proc_resp     = '0;
    mem_req.cmd   = dcache_pkg::BUS_NONE;
    mem_req.addr  = '0;
    mem_req.data  = '0;
    cache_wr      = '0;
    miss_wr       = 1'b0;
    fill_addr.raw = '0;

    if (fill_cycle) begin
      // Line comes back from memory, put it where the miss was recorded
      fill_addr.raw   = miss_tbl[mem_resp.tag];
      cache_wr.en     = 1'b1;
      cache_wr.idx    = fill_addr.f.idx;
      cache_wr.tag    = fill_addr.f.tag;
      cache_wr.data   = mem_resp.data;
      proc_resp.data  = mem_resp.data;
      proc_resp.valid = 1'b1;
      proc_resp.tag   = mem_resp.tag;
    end else if (is_load) begin
      if (lookup_hit) begin
        proc_resp.data  = lookup_data;
        proc_resp.valid = 1'b1;                 // Tag stays 0 on a hit
      end else begin
        mem_req.cmd   = dcache_pkg::BUS_LOAD;
        mem_req.addr  = word_addr;
        proc_resp.tag = mem_resp.response;      // 0 means retry
        miss_wr       = (mem_resp.response != '0);
      end
    end else if (is_store) begin
      // Write through and allocate
      mem_req.cmd   = dcache_pkg::BUS_STORE;
      mem_req.addr  = word_addr;
      mem_req.data  = proc_req.data;
      cache_wr.en   = 1'b1;
      cache_wr.idx  = proc_req.addr.f.idx;
      cache_wr.tag  = proc_req.addr.f.tag;
      cache_wr.data = proc_req.data;
    end
  end

  //////////////////////////////////////////////////
  // Miss table
  //////////////////////////////////////////////////

  // Written at the edge after a granted miss
  always_ff @(posedge clock) begin
    if (miss_wr) begin
      miss_tbl[mem_resp.response] <= proc_req.addr.raw;
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Load/store queue never issues the unused code
  a_cmd_legal : assert property (
    @(posedge clock) disable iff (!rst_n)
    proc_req.cmd != 2'b11
  ) else $error("dcache_ctrl: illegal processor command");

  // A fill blocks new loads towards memory
  a_no_load_in_fill : assert property (
    @(posedge clock) disable iff (!rst_n)
    fill_cycle |-> (mem_req.cmd != dcache_pkg::BUS_LOAD)
  ) else $error("dcache_ctrl: memory load issued during fill");

  // Untagged valid answer only from the storage
  a_hit_resp : assert property (
    @(posedge clock) disable iff (!rst_n)
    (proc_resp.valid && proc_resp.tag == '0) |-> lookup_hit
  ) else $error("dcache_ctrl: valid response without hit");

endmodule

`default_nettype wire

// ==== logic/dcache_defs.svh ====
// Cache geometry and memory bus widths, whole 64-bit words only
// Direct mapped; index plus tag plus offset must stay below the address width
// Memory tag 0 is reserved for "no transaction"

`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

//////////////////////////////////////////////////
// Word and address
//////////////////////////////////////////////////

`define DCACHE_WORD_BITS 64
`define DCACHE_ADDR_BITS 64

//////////////////////////////////////////////////
// Cache geometry
//////////////////////////////////////////////////

`define DCACHE_IDX_BITS  5    // 32 lines
`define DCACHE_TAG_BITS  8    // Stored cache tag
`define DCACHE_OFS_BITS  3    // Byte within a word
`define DCACHE_LINES     (1 << `DCACHE_IDX_BITS)

// Upper address bits that the cache ignores
`define DCACHE_HI_BITS \
  (`DCACHE_ADDR_BITS - `DCACHE_TAG_BITS - `DCACHE_IDX_BITS - `DCACHE_OFS_BITS)

//////////////////////////////////////////////////
// Memory transaction tags
//////////////////////////////////////////////////

`define MEM_TAG_BITS     4
`define MEM_TAG_COUNT    15   // Tags 1..15 usable

`endif

// ==== logic/dcache_mem.sv ====
// Direct-mapped line storage, one word per line
// Lookup is combinational; writes land at the next rising edge

`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_mem (
  input  logic                          clock,
  input  logic                          rst_n,
  input  dcache_pkg::cache_lookup_t     lookup,
  input  dcache_pkg::cache_write_t      cache_wr,
  output logic [`DCACHE_WORD_BITS-1:0]  lookup_data,
  output logic                          lookup_hit
);

  logic [`DCACHE_WORD_BITS-1:0] data_mem [`DCACHE_LINES];
  logic [`DCACHE_TAG_BITS-1:0]  tag_mem  [`DCACHE_LINES];
  logic [`DCACHE_LINES-1:0]     line_valid;

  //////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////

  // Valid bits, all lines empty after reset
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      line_valid <= '0;
    end else if (cache_wr.en) begin
      line_valid[cache_wr.idx] <= 1'b1;
    end
  end

  // Payload arrays
  always_ff @(posedge clock) begin
    if (cache_wr.en) begin
      data_mem[cache_wr.idx] <= cache_wr.data;
      tag_mem[cache_wr.idx]  <= cache_wr.tag;
    end
  end

  //////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////

  assign lookup_data = data_mem[lookup.idx];
  assign lookup_hit  = line_valid[lookup.idx] &&
                       (tag_mem[lookup.idx] == lookup.tag);  // Tag match on a live line

  // An unknown index would corrupt an arbitrary line
  a_wr_idx_known : assert property (
    @(posedge clock) disable iff (!rst_n)
    cache_wr.en |-> !$isunknown(cache_wr.idx)
  ) else $error("dcache_mem: write index unknown");

endmodule

`default_nettype wire

// ==== logic/dcache_pkg.sv ====
// Types shared by the cache, its processor port and the memory bus
// Command code 2'b11 is illegal on both buses

`default_nettype none

`include "dcache_defs.svh"

package dcache_pkg;

  // Bus command, same encoding towards memory and from the processor
  typedef enum logic [1:0] {
    BUS_NONE  = 2'b00,
    BUS_LOAD  = 2'b01,
    BUS_STORE = 2'b10
  } bus_cmd_e;

  // Field view of an address
  typedef struct packed {
    logic [`DCACHE_HI_BITS-1:0]  unused_hi;
    logic [`DCACHE_TAG_BITS-1:0] tag;
    logic [`DCACHE_IDX_BITS-1:0] idx;
    logic [`DCACHE_OFS_BITS-1:0] ofs;
  } dcache_addr_fields_t;

  // One address word, raw for the memory bus, fields for the cache
  typedef union packed {
    logic [`DCACHE_ADDR_BITS-1:0] raw;
    dcache_addr_fields_t          f;
  } dcache_addr_u;

  //////////////////////////////////////////////////
  // Processor side
  //////////////////////////////////////////////////

  typedef struct packed {
    bus_cmd_e                     cmd;
    dcache_addr_u                 addr;
    logic [`DCACHE_WORD_BITS-1:0] data;   // Store data
  } proc_req_t;

  typedef struct packed {
    logic [`DCACHE_WORD_BITS-1:0] data;
    logic                         valid;
    logic [`MEM_TAG_BITS-1:0]     tag;    // 0 on hit, memory tag on miss/fill
  } proc_resp_t;

  //////////////////////////////////////////////////
  // Memory side
  //////////////////////////////////////////////////

  typedef struct packed {
    bus_cmd_e                     cmd;
    logic [`DCACHE_ADDR_BITS-1:0] addr;   // Word aligned
    logic [`DCACHE_WORD_BITS-1:0] data;
  } mem_req_t;

  typedef struct packed {
    logic [`MEM_TAG_BITS-1:0]     response; // Granted tag, 0 when busy
    logic [`MEM_TAG_BITS-1:0]     tag;      // Fill tag, 0 when no fill
    logic [`DCACHE_WORD_BITS-1:0] data;
  } mem_resp_t;

  //////////////////////////////////////////////////
  // Controller to storage
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [`DCACHE_IDX_BITS-1:0] idx;
    logic [`DCACHE_TAG_BITS-1:0] tag;
  } cache_lookup_t;

  typedef struct packed {
    logic                         en;
    logic [`DCACHE_IDX_BITS-1:0]  idx;
    logic [`DCACHE_TAG_BITS-1:0]  tag;
    logic [`DCACHE_WORD_BITS-1:0] data;
  } cache_write_t;

endpackage

`default_nettype wire

// ==== logic/dcache_top.sv ====
// Data cache subsystem between load/store queue and tagged memory
// No handshake: processor retries on fill cycles and on a zero grant

`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_top (
  input  logic                   clock,
  input  logic                   rst_n,
  input  dcache_pkg::proc_req_t  proc_req,
  output dcache_pkg::proc_resp_t proc_resp,
  output dcache_pkg::mem_req_t   mem_req,
  input  dcache_pkg::mem_resp_t  mem_resp
);

  //////////////////////////////////////////////////
  // Controller to storage
  //////////////////////////////////////////////////

  dcache_pkg::cache_lookup_t    lookup;
  dcache_pkg::cache_write_t     cache_wr;
  logic [`DCACHE_WORD_BITS-1:0] lookup_data;
  logic                         lookup_hit;

  dcache_ctrl u_ctrl (
    .clock       (clock),
    .rst_n       (rst_n),
    .proc_req    (proc_req),
    .proc_resp   (proc_resp),
    .mem_req     (mem_req),
    .mem_resp    (mem_resp),
    .lookup      (lookup),
    .lookup_data (lookup_data),
    .lookup_hit  (lookup_hit),
    .cache_wr    (cache_wr)
  );

  // Line storage
  dcache_mem u_mem (
    .clock       (clock),
    .rst_n       (rst_n),
    .lookup      (lookup),
    .cache_wr    (cache_wr),
    .lookup_data (lookup_data),
    .lookup_hit  (lookup_hit)
  );

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+logic
logic/dcache_pkg.sv
logic/dcache_mem.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
tb/dmem_model.sv
tb/dcache_tb.sv

// ==== tb/dcache_tb.sv ====
// Directed tests for the data cache subsystem against a behavioural memory
// Expected words come from a reference memory kept by the testbench

`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_tb;

  localparam int FILL_TIMEOUT = 20;
  localparam int FILL_DELAY   = 4;

  logic                   clock;
  logic                   rst_n;
  logic                   busy;
  dcache_pkg::proc_req_t  proc_req;
  dcache_pkg::proc_resp_t proc_resp;
  dcache_pkg::mem_req_t   mem_req;
  dcache_pkg::mem_resp_t  mem_resp;

  logic [63:0] ref_mem [logic [63:0]];
  logic [31:0] lfsr;
  int          errors;
  int          checks;

  dcache_top u_dut (
    .clock     (clock),
    .rst_n     (rst_n),
    .proc_req  (proc_req),
    .proc_resp (proc_resp),
    .mem_req   (mem_req),
    .mem_resp  (mem_resp)
  );

  dmem_model u_dmem (
    .clock    (clock),
    .rst_n    (rst_n),
    .busy     (busy),
    .mem_req  (mem_req),
    .mem_resp (mem_resp)
  );

  always #5 clock = ~clock;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r    = {r[62:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [63:0] word_addr(input logic [63:0] a);
    return {a[63:`DCACHE_OFS_BITS], {`DCACHE_OFS_BITS{1'b0}}};
  endfunction

  // Same content rule as the memory model
  function automatic logic [63:0] expected_word(input logic [63:0] a);
    logic [63:0] w;
    w = word_addr(a);
    if (ref_mem.exists(w)) begin
      return ref_mem[w];
    end
    return {w[31:0], w[63:32]} ^ 64'h9e37_79b9_7f4a_7c15;
  endfunction

  // Random address on a chosen line
  function automatic logic [63:0] make_addr(input logic [`DCACHE_IDX_BITS-1:0] idx);
    dcache_pkg::dcache_addr_u a;
    a.raw   = rand_bits(40);
    a.f.idx = idx;
    return a.raw;
  endfunction

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic drive(input dcache_pkg::bus_cmd_e cmd, input logic [63:0] addr,
                       input logic [63:0] data);
    @(posedge clock);
    #1;
    proc_req.cmd      = cmd;
    proc_req.addr.raw = addr;
    proc_req.data     = data;
  endtask

  task automatic issue_miss(input logic [63:0] addr, output logic [3:0] tag);
    drive(dcache_pkg::BUS_LOAD, addr, '0);
    @(negedge clock);
    tag = proc_resp.tag;
    check(64'(proc_resp.valid), 64'd0, "miss valid");
    check(64'(tag != '0), 64'd1, "miss granted a tag");
    check(64'(mem_req.cmd), 64'(dcache_pkg::BUS_LOAD), "miss memory command");
    check(mem_req.addr, word_addr(addr), "miss memory address");
  endtask

  // Cycles counted from the miss, 0 on timeout
  task automatic wait_fill(input logic [3:0] tag, input logic [63:0] addr, output int cycles);
    cycles = 0;
    for (int n = 1; n <= FILL_TIMEOUT && cycles == 0; n++) begin
      @(negedge clock);
      if (proc_resp.tag == tag) begin
        cycles = n;
        check(64'(proc_resp.valid), 64'd1, "fill valid");
        check(proc_resp.data, expected_word(addr), "fill data");
      end
    end
    if (cycles == 0) begin
      errors++;
      $display("timeout: no fill for tag %0d within %0d cycles", tag, FILL_TIMEOUT);
    end
  endtask

  task automatic miss_and_fill(input logic [63:0] addr, output int cycles);
    logic [3:0] tag;
    issue_miss(addr, tag);
    drive(dcache_pkg::BUS_NONE, '0, '0);
    wait_fill(tag, addr, cycles);
  endtask

  task automatic expect_hit(input logic [63:0] addr);
    drive(dcache_pkg::BUS_LOAD, addr, '0);
    @(negedge clock);
    check(64'(proc_resp.valid), 64'd1, "hit valid");
    check(64'(proc_resp.tag), 64'd0, "hit tag");
    check(proc_resp.data, expected_word(addr), "hit data");
    check(64'(mem_req.cmd), 64'(dcache_pkg::BUS_NONE), "no memory request on hit");
    drive(dcache_pkg::BUS_NONE, '0, '0);
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_miss_then_hit(input logic [63:0] addr);
    int cycles;
    miss_and_fill(addr, cycles);
    check(64'(cycles), 64'(FILL_DELAY), "fill latency");
    expect_hit(addr);
  endtask

  task automatic test_store(input logic [63:0] addr);
    logic [63:0] data;
    int          cycles;
    data = rand_bits(64);
    drive(dcache_pkg::BUS_STORE, addr, data);
    @(negedge clock);
    check(64'(proc_resp.valid), 64'd0, "store valid");
    check(64'(mem_req.cmd), 64'(dcache_pkg::BUS_STORE), "store memory command");
    check(mem_req.addr, word_addr(addr), "store memory address");
    check(mem_req.data, data, "store memory data");
    ref_mem[word_addr(addr)] = data;
    drive(dcache_pkg::BUS_NONE, '0, '0);
    expect_hit(addr);
    // Evict, then read the stored word back from memory
    miss_and_fill(addr ^ (64'h1 << (`DCACHE_OFS_BITS + `DCACHE_IDX_BITS)), cycles);
    miss_and_fill(addr, cycles);
  endtask

  task automatic test_conflict(input logic [63:0] addr);
    int cycles;
    miss_and_fill(addr ^ (64'h80 << (`DCACHE_OFS_BITS + `DCACHE_IDX_BITS)), cycles);
    miss_and_fill(addr, cycles);                 // Line was taken by the other tag
  endtask

  task automatic test_fill_priority(input logic [63:0] held, input logic [63:0] missed);
    logic [3:0] tag;
    int         cycles;
    miss_and_fill(held, cycles);
    issue_miss(missed, tag);
    drive(dcache_pkg::BUS_LOAD, held, '0);       // Held across the fill
    cycles = 0;
    for (int n = 1; n <= FILL_TIMEOUT && cycles == 0; n++) begin
      @(negedge clock);
      if (proc_resp.tag == tag) begin
        cycles = n;
        check(proc_resp.data, expected_word(missed), "fill data over held load");
        check(64'(mem_req.cmd), 64'(dcache_pkg::BUS_NONE), "no memory request in fill");
      end
    end
    if (cycles == 0) begin
      errors++;
      $display("timeout: fill never overrode the held load");
    end
    @(negedge clock);
    check(64'(proc_resp.valid), 64'd1, "retried load valid");
    check(64'(proc_resp.tag), 64'd0, "retried load tag");
    check(proc_resp.data, expected_word(held), "retried load data");
    drive(dcache_pkg::BUS_NONE, '0, '0);
  endtask

  task automatic test_busy(input logic [63:0] addr);
    int cycles;
    drive(dcache_pkg::BUS_LOAD, addr, '0);
    busy = 1'b1;
    @(negedge clock);
    check(64'(proc_resp.valid), 64'd0, "busy load valid");
    check(64'(proc_resp.tag), 64'd0, "busy load tag");
    drive(dcache_pkg::BUS_NONE, '0, '0);
    for (int n = 0; n < 2 * FILL_DELAY; n++) begin
      @(negedge clock);
      check(64'(proc_resp.valid), 64'd0, "no fill after busy load");
    end
    @(posedge clock);
    #1;
    busy = 1'b0;
    miss_and_fill(addr, cycles);
  endtask

  task automatic test_outstanding();
    logic [63:0] addrs [3];
    logic [3:0]  tags [3];
    int          seen;
    for (int i = 0; i < 3; i++) begin
      addrs[i] = make_addr(5'(20 + i));
      issue_miss(addrs[i], tags[i]);
    end
    drive(dcache_pkg::BUS_NONE, '0, '0);
    check(64'(tags[0] != tags[1] && tags[1] != tags[2] && tags[0] != tags[2]), 64'd1,
          "distinct tags");
    seen = 0;
    for (int n = 0; n < FILL_TIMEOUT && seen < 3; n++) begin
      @(negedge clock);
      for (int i = 0; i < 3; i++) begin
        if (proc_resp.tag != '0 && proc_resp.tag == tags[i]) begin
          seen++;
          check(proc_resp.data, expected_word(addrs[i]), "outstanding fill data");
        end
      end
    end
    if (seen < 3) begin
      errors++;
      $display("timeout: only %0d of 3 outstanding fills arrived", seen);
    end
    // Each fill must have landed on the line of its own tag's address
    for (int i = 0; i < 3; i++) begin
      expect_hit(addrs[i]);
    end
  endtask

  initial begin
    logic [63:0] addr_a;
    clock    = 1'b0;
    rst_n    = 1'b0;
    busy     = 1'b0;
    proc_req = '0;
    lfsr     = 32'h2f7c_fca4;
    errors   = 0;
    checks   = 0;
    repeat (4) @(posedge clock);
    #1;
    rst_n = 1'b1;

    addr_a = make_addr(5'd3);
    test_miss_then_hit(addr_a);
    test_store(make_addr(5'd7));
    test_conflict(addr_a);
    test_fill_priority(make_addr(5'd10), make_addr(5'd11));
    test_busy(make_addr(5'd12));
    test_outstanding();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/dmem_model.sv ====
// Behavioural tagged memory for the data cache testbench
// Grants the lowest free tag; fill data is read at grant time, stores apply at once
// Unwritten words read back as a pattern of their address

`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dmem_model (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic                  busy,
  input  dcache_pkg::mem_req_t  mem_req,
  output dcache_pkg::mem_resp_t mem_resp
);

  localparam int FILL_DELAY = 4;     // Cycles from granted request to fill

  logic [`DCACHE_WORD_BITS-1:0] words [logic [`DCACHE_ADDR_BITS-1:0]];
  logic [`MEM_TAG_COUNT:0]      tag_used;   // Bit 0 never used
  logic [`MEM_TAG_BITS-1:0]     grant_tag;
  logic [`MEM_TAG_BITS-1:0]     fill_tag;
  logic [`DCACHE_WORD_BITS-1:0] fill_data;

  // Fills waiting to be presented, oldest first
  int unsigned                  due_q [$];
  logic [`MEM_TAG_BITS-1:0]     tag_q [$];
  logic [`DCACHE_WORD_BITS-1:0] data_q [$];
  int unsigned                  cyc;

  function automatic logic [63:0] read_word(input logic [63:0] addr);
    if (words.exists(addr)) begin
      return words[addr];
    end
    return {addr[31:0], addr[63:32]} ^ 64'h9e37_79b9_7f4a_7c15;
  endfunction

  // Tag on offer this cycle, taken only by a load
  always_comb begin
    grant_tag = '0;
    if (!busy) begin
      for (int t = `MEM_TAG_COUNT; t >= 1; t--) begin
        if (!tag_used[t[`MEM_TAG_BITS-1:0]]) begin
          grant_tag = t[`MEM_TAG_BITS-1:0];
        end
      end
    end
  end

  assign mem_resp = {grant_tag, fill_tag, fill_data};

  always @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      tag_used  <= '0;
      fill_tag  <= '0;
      fill_data <= '0;
      cyc = 0;
      due_q.delete();
      tag_q.delete();
      data_q.delete();
    end else begin
      cyc = cyc + 1;
      if (fill_tag != '0) begin
        tag_used[fill_tag] <= 1'b0;      // Fill consumed at this edge
      end
      if (mem_req.cmd == dcache_pkg::BUS_LOAD && grant_tag != '0) begin
        tag_used[grant_tag] <= 1'b1;
        due_q.push_back(cyc + FILL_DELAY - 1);
        tag_q.push_back(grant_tag);
        data_q.push_back(read_word(mem_req.addr));
      end
      if (mem_req.cmd == dcache_pkg::BUS_STORE) begin
        words[mem_req.addr] = mem_req.data;
      end
      // One fill per cycle, late ones slip
      if (due_q.size() != 0 && due_q[0] <= cyc) begin
        fill_tag  <= tag_q.pop_front();
        fill_data <= data_q.pop_front();
        void'(due_q.pop_front());
      end else begin
        fill_tag  <= '0;
        fill_data <= '0;
      end
    end
  end

endmodule

`default_nettype wire
